//--- Makefile
# Verilator flow for the vector issue block

VERILATOR  ?= verilator
TOP        := simd_issue_tb
FILELIST   := build.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0 --Mdir $(OBJ_DIR)
PASS_MSG   := STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
logic/simd_pkg.sv
logic/simd_latency_decode.sv
logic/simd_score_board.sv
logic/simd_wb_delay_line.sv
logic/simd_issue_top.sv
verif/simd_issue_asserts.sv
verif/simd_issue_tb.sv

//--- logic/simd_issue_top.sv
// Vector issue block
// Decodes the execute latency of the offered instruction, accepts it when
// the scoreboard allows and returns it on the writeback port after that many cycles

module simd_issue_top
    import simd_pkg::*;
#(
    parameter int max_lat = max_stages
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        issue_ready_i,  // Instruction offered this cycle
    input  instr_type_t instr_type_i,
    input  unit_t       unit_i,
    input  sew_t        sew_i,
    input  rd_t         rd_i,
    input  logic        flush_i,
    output logic        stall_o,
    output logic        wb_valid_o,
    output rd_t         wb_rd_o,
    output instr_type_t wb_type_o,
    output lat_t        exe_lat_o
);

    lat_t latency;
    logic issue_fire;

    simd_latency_decode u_decode (
        .instr_type_i (instr_type_i),
        .sew_i        (sew_i),
        .lat_o        (latency)
    );

    // Accepted only for the vector unit and while not stalled
    assign issue_fire = issue_ready_i & (unit_i == unit_simd) & ~stall_o;

    simd_score_board #(
        .max_lat (max_lat)
    ) u_score (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .flush_i      (flush_i),
        .issue_fire_i (issue_fire),
        .lat_i        (latency),
        .stall_o      (stall_o)
    );

    simd_wb_delay_line #(
        .max_lat (max_lat)
    ) u_wb (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .flush_i      (flush_i),
        .issue_fire_i (issue_fire),
        .lat_i        (latency),
        .rd_i         (rd_i),
        .type_i       (instr_type_i),
        .wb_valid_o   (wb_valid_o),
        .wb_rd_o      (wb_rd_o),
        .wb_type_o    (wb_type_o)
    );

    assign exe_lat_o = latency;

endmodule

//--- logic/simd_latency_decode.sv
// Vector latency decode
// Sorts the offered instruction into multiply, reduction or single cycle
// and gives its execute latency for the element width in use

module simd_latency_decode
    import simd_pkg::*;
(
    input  instr_type_t instr_type_i,
    input  sew_t        sew_i,
    output lat_t        lat_o
);

    logic is_mul;
    logic is_red;

    // Class of the offered instruction
    always_comb begin
        is_mul = 1'b0;
        is_red = 1'b0;
        case (instr_type_i)
            vmul, vmulh, vmulhu, vmulhsu,
            vmadd, vnmsub, vmacc, vnmsac: begin
                is_mul = 1'b1;
            end
            vredsum, vredand, vredor, vredxor: begin
                is_red = 1'b1;
            end
            default: begin
                is_mul = 1'b0;  // Single cycle ops
            end
        endcase
    end

    always_comb begin
        if (is_mul) begin
            lat_o = (sew_i == sew_64) ? lat_mul_wide : lat_mul;
        end else if (is_red) begin
            // SEW 8 and 16 share the full tree depth
            case (sew_i)
                sew_8, sew_16: lat_o = lat_red_narrow;
                sew_32:        lat_o = lat_red_32;
                sew_64:        lat_o = lat_red_64;
                default:       lat_o = lat_red_narrow;
            endcase
        end else begin
            lat_o = lat_single;
        end
    end

endmodule

//--- logic/simd_pkg.sv
// SIMD issue package
// Vector length, element widths, functional-unit tags, vector instruction
// kinds and the execute latencies that follow from them

package simd_pkg;

    // Vector register length in bits
    localparam int vlen = 128;

    // Depth of the reduction tree over the narrowest elements
    localparam int red_depth = $clog2(vlen / 8);

    // Longest execute latency, a SEW 8 reduction
    localparam int max_stages = red_depth + 1;

    typedef logic [3:0] lat_t;  // Execute latency in cycles
    typedef logic [4:0] rd_t;   // Destination vector register

    typedef enum logic [1:0] {
        sew_8  = 2'b00,
        sew_16 = 2'b01,
        sew_32 = 2'b10,
        sew_64 = 2'b11
    } sew_t;

    typedef enum logic [1:0] {
        unit_alu  = 2'b00,
        unit_mem  = 2'b01,
        unit_simd = 2'b10,  // Only tag accepted by the vector issue logic
        unit_ctrl = 2'b11
    } unit_t;

    typedef enum logic [4:0] {
        // Multiply group
        vmul    = 5'd0,
        vmulh   = 5'd1,
        vmulhu  = 5'd2,
        vmulhsu = 5'd3,
        vmadd   = 5'd4,
        vnmsub  = 5'd5,
        vmacc   = 5'd6,
        vnmsac  = 5'd7,
        // Reduction group
        vredsum = 5'd8,
        vredand = 5'd9,
        vredor  = 5'd10,
        vredxor = 5'd11,
        // Single cycle group
        vadd    = 5'd12,
        vsub    = 5'd13,
        vand    = 5'd14,
        vor     = 5'd15,
        vxor    = 5'd16,
        vmv     = 5'd17
    } instr_type_t;

    // Execute latencies per class
    localparam lat_t lat_single   = lat_t'(1);
    localparam lat_t lat_mul      = lat_t'(2);
    localparam lat_t lat_mul_wide = lat_t'(3);  // SEW 64 multiply

    // Reductions shorten as elements widen, one tree level per doubling
    localparam lat_t lat_red_narrow = lat_t'(red_depth + 1);  // SEW 8 and 16
    localparam lat_t lat_red_32     = lat_t'(red_depth);
    localparam lat_t lat_red_64     = lat_t'(red_depth - 1);

endpackage

//--- logic/simd_score_board.sv
// Vector writeback scoreboard
// Tracks every multi-cycle instruction in flight in one occupancy lane per
// latency and raises a registered stall whenever a new issue could land
// its writeback in the same cycle as an older, longer instruction

module simd_score_board
    import simd_pkg::*;
#(
    parameter int max_lat = max_stages
) (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic flush_i,
    input  logic issue_fire_i,  // Instruction accepted at this edge
    input  lat_t lat_i,         // Latency of the offered instruction
    output logic stall_o
);

    // Lane l holds instructions of latency l, position 0 is the cycle
    // right after acceptance and position l-1 is the writeback cycle
    //
    //   lat 2 -> |0|1|
    //   lat 3 -> |0|1|2|
    //   lat 4 -> |0|1|2|3|
    //
    // Positions at or past l stay empty
    logic [max_lat-1:0] occ_q [max_lat:2];
    logic [max_lat-1:0] occ_d [max_lat:2];

    logic stall_d;
    logic stall_q;

    // Next lane contents, one shift per cycle
    always_comb begin
        for (int l = 2; l <= max_lat; l++) begin
            occ_d[l][0] = issue_fire_i & (lat_i == lat_t'(l));  // Entry survives a flush
            for (int j = 1; j < max_lat; j++) begin
                if (j < l) begin
                    occ_d[l][j] = occ_q[l][j-1] & ~flush_i;
                end else begin
                    occ_d[l][j] = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            for (int l = 2; l <= max_lat; l++) begin
                occ_q[l] <= '0;
            end
        end else begin
            for (int l = 2; l <= max_lat; l++) begin
                occ_q[l] <= occ_d[l];
            end
        end
    end

    // Collision check
    //
    // The stall registered here gates the edge after next, so it is
    // worked out from the lane contents after this edge, which already
    // include the instruction being accepted now. An older entry of
    // latency l at position p then retires together with a new issue of
    // latency c when p = l - c - 1.
    //
    // The instruction offered at that later edge may differ from the one
    // decoded now, so every latency shorter than l is checked and not
    // only lat_i. Longer or equal latencies can never meet an older entry.
    always_comb begin
        stall_d = 1'b0;
        for (int l = 2; l <= max_lat; l++) begin
            for (int c = 1; c < l; c++) begin
                stall_d = stall_d | occ_d[l][l-c-1];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            stall_q <= 1'b0;
        end else begin
            stall_q <= stall_d;
        end
    end

    assign stall_o = stall_q;

endmodule

//--- logic/simd_wb_delay_line.sv
// Vector writeback delay line
// Carries destination and type of each accepted instruction down a lane
// sized to its latency and presents it on the single writeback port

module simd_wb_delay_line
    import simd_pkg::*;
#(
    parameter int max_lat = max_stages
) (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        flush_i,
    input  logic        issue_fire_i,
    input  lat_t        lat_i,
    input  rd_t         rd_i,
    input  instr_type_t type_i,
    output logic        wb_valid_o,
    output rd_t         wb_rd_o,
    output instr_type_t wb_type_o
);

    // Last position of every lane
    logic [max_lat:1] lane_vld;
    rd_t              lane_rd   [max_lat:1];
    instr_type_t      lane_type [max_lat:1];

    for (genvar l = 1; l <= max_lat; l++) begin : g_lane
        logic        vld_q [l];
        rd_t         rd_q  [l];
        instr_type_t typ_q [l];
        logic        load;

        assign load = issue_fire_i & (lat_i == lat_t'(l));

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                for (int j = 0; j < l; j++) begin
                    vld_q[j] <= 1'b0;
                end
            end else begin
                vld_q[0] <= load;  // Kept even on a flush edge
                for (int j = 1; j < l; j++) begin
                    vld_q[j] <= vld_q[j-1] & ~flush_i;
                end
            end
        end

        always_ff @(posedge clk_i) begin
            if (load) begin
                rd_q[0]  <= rd_i;
                typ_q[0] <= type_i;
            end
            for (int j = 1; j < l; j++) begin
                rd_q[j]  <= rd_q[j-1];
                typ_q[j] <= typ_q[j-1];
            end
        end

        assign lane_vld[l]  = vld_q[l-1];
        assign lane_rd[l]   = rd_q[l-1];
        assign lane_type[l] = typ_q[l-1];
    end

    // At most one lane retires per cycle, so a masked OR picks it
    always_comb begin
        wb_valid_o = |lane_vld;
        wb_rd_o    = '0;
        wb_type_o  = instr_type_t'('0);
        for (int l = 1; l <= max_lat; l++) begin
            if (lane_vld[l]) begin
                wb_rd_o   = wb_rd_o | lane_rd[l];
                wb_type_o = instr_type_t'(wb_type_o | lane_type[l]);
            end
        end
    end

endmodule

//--- verif/simd_issue_asserts.sv
// Writeback and stall assertions for the vector issue block
// Follows pending writebacks from the accepted issues and checks the
// writeback port, stall release and reset state against them

module simd_issue_asserts
    import simd_pkg::*;
(
    input logic clk_i,
    input logic rstn_i,
    input logic flush_i,
    input logic issue_fire_i,
    input lat_t lat_i,
    input logic stall_i,
    input logic wb_valid_i
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] due_q;    // Bit n set when a writeback lands n cycles from now
    logic [15:0] new_bit;
    int unsigned assert_errors = 0;

    assign new_bit = issue_fire_i ? (16'd1 << (lat_i - 4'd1)) : '0;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            due_q <= '0;
        end else if (flush_i) begin
            due_q <= new_bit;  // Only the entry survives
        end else begin
            due_q <= (due_q >> 1) | new_bit;
        end
    end

    a_wb_when_due: assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_valid_i == due_q[0])
        else begin assert_errors++; $error("writeback valid does not match issue history"); end

    // A new issue never lands on an older writeback
    a_no_collision: assert property (@(posedge clk_i) disable iff (!rstn_i)
        issue_fire_i && !flush_i |-> !due_q[lat_i])
        else begin assert_errors++; $error("accepted issue shares a writeback cycle"); end

    a_stall_release: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (due_q == '0) && !issue_fire_i |=> !stall_i)
        else begin assert_errors++; $error("stall held with nothing in flight"); end

    a_reset_quiet: assert property (@(posedge clk_i) $rose(rstn_i) |-> !stall_i && !wb_valid_i)
        else begin assert_errors++; $error("stall or writeback active after reset"); end

endmodule

bind simd_issue_top simd_issue_asserts u_asserts (
    .clk_i        (clk_i),
    .rstn_i       (rstn_i),
    .flush_i      (flush_i),
    .issue_fire_i (issue_fire),
    .lat_i        (latency),
    .stall_i      (stall_o),
    .wb_valid_i   (wb_valid_o)
);

//--- verif/simd_issue_tb.sv
// Testbench for the vector issue block
// Offers directed and random vector instructions, predicts latency and
// writeback cycle from its own model and compares the DUT against it

module simd_issue_tb
    import simd_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int unsigned seed          = 32'h3902_6a1a;
    localparam int          num_cycles    = 3000;
    localparam int          drain_timeout = 64;
    localparam int          idle_cycles   = 12;

    typedef struct {
        rd_t         rd;
        instr_type_t typ;
        int unsigned due;  // Cycle the writeback shows up
    } wb_entry_t;

    logic        clk_i;
    logic        rstn_i;
    logic        issue_ready_i;
    instr_type_t instr_type_i;
    unit_t       unit_i;
    sew_t        sew_i;
    rd_t         rd_i;
    logic        flush_i;
    logic        stall_o;
    logic        wb_valid_o;
    rd_t         wb_rd_o;
    instr_type_t wb_type_o;
    lat_t        exe_lat_o;

    wb_entry_t   pending [$];
    int unsigned cycle;
    int          mismatch_count;
    int          error_count;

    simd_issue_top u_dut (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .issue_ready_i (issue_ready_i),
        .instr_type_i  (instr_type_i),
        .unit_i        (unit_i),
        .sew_i         (sew_i),
        .rd_i          (rd_i),
        .flush_i       (flush_i),
        .stall_o       (stall_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_type_o     (wb_type_o),
        .exe_lat_o     (exe_lat_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    // Latency rules of the vector unit at VLEN 128
    function automatic lat_t exp_latency(input instr_type_t typ, input sew_t sew);
        lat_t lat;
        case (typ)
            vmul, vmulh, vmulhu, vmulhsu, vmadd, vnmsub, vmacc, vnmsac: begin
                lat = (sew == sew_64) ? 4'd3 : 4'd2;
            end
            vredsum, vredand, vredor, vredxor: begin
                case (sew)
                    sew_8, sew_16: lat = 4'd5;
                    sew_32:        lat = 4'd4;
                    default:       lat = 4'd3;
                endcase
            end
            default: lat = 4'd1;
        endcase
        return lat;
    endfunction

    task automatic check_lat(input lat_t got, input lat_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: exe_lat_o is %0d, expected %0d", $time, got, exp);
        end
    endtask

    task automatic check_wb(input rd_t got_rd, input instr_type_t got_type,
                            input rd_t exp_rd, input instr_type_t exp_type);
        if (got_rd !== exp_rd || got_type !== exp_type) begin
            mismatch_count++;
            $display("mismatch at %0t: writeback rd %0d type %s, expected rd %0d type %s",
                     $time, got_rd, got_type.name(), exp_rd, exp_type.name());
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            mismatch_count++;
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic drive_offer(input logic ready, input unit_t unit, input instr_type_t typ,
                               input sew_t sew, input rd_t rd, input logic flush);
        @(posedge clk_i);
        issue_ready_i <= ready;
        unit_i        <= unit;
        instr_type_i  <= typ;
        sew_i         <= sew;
        rd_i          <= rd;
        flush_i       <= flush;
    endtask

    task automatic drive_idle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            drive_offer(1'b0, unit_alu, vadd, sew_8, '0, 1'b0);
        end
    endtask

    // Issue port model and writeback compare at the falling edge
    always @(negedge clk_i) begin : compare_proc
        int   hits;
        int   hit_idx;
        lat_t lat_exp;
        if (!rstn_i) begin
            cycle = 0;
            pending.delete();
        end else begin
            cycle++;
            lat_exp = exp_latency(instr_type_i, sew_i);
            check_lat(exe_lat_o, lat_exp);
            hits    = 0;
            hit_idx = -1;
            foreach (pending[i]) begin
                if (pending[i].due == cycle) begin
                    hits++;
                    hit_idx = i;
                end
            end
            if (hits > 1) begin
                error_count++;
                $display("error: %0d writebacks expected in the same cycle at %0t", hits, $time);
            end
            check_flag(wb_valid_o, hits != 0, "wb_valid_o");
            if (hits != 0 && wb_valid_o) begin
                check_wb(wb_rd_o, wb_type_o, pending[hit_idx].rd, pending[hit_idx].typ);
            end
            // Missed writebacks stay queued for the drain check
            for (int i = pending.size() - 1; i >= 0; i--) begin
                if (pending[i].due == cycle && wb_valid_o) begin
                    pending.delete(i);
                end
            end
            if (flush_i) pending.delete();  // Only later writebacks remain here
            if (issue_ready_i && unit_i == unit_simd && !stall_o) begin
                pending.push_back('{rd: rd_i, typ: instr_type_i, due: cycle + int'(lat_exp)});
            end
        end
    end

    initial begin : stimulus
        int waited;
        int asserts_failed;
        void'($urandom(seed));
        mismatch_count = 0;
        error_count    = 0;
        rstn_i         = 1'b0;
        issue_ready_i  = 1'b0;
        instr_type_i   = vadd;
        unit_i         = unit_alu;
        sew_i          = sew_8;
        rd_i           = '0;
        flush_i        = 1'b0;

        repeat (2) @(posedge clk_i);
        rstn_i <= 1'b1;
        @(negedge clk_i);
        check_flag(stall_o, 1'b0, "stall_o after reset");
        check_flag(wb_valid_o, 1'b0, "wb_valid_o after reset");
        drive_idle(3);

        // Every type at every element width
        for (int t = 0; t <= 17; t++) begin
            for (int s = 0; s < 4; s++) begin
                drive_offer(1'b1, unit_simd, instr_type_t'(t), sew_t'(s), rd_t'(t + s), 1'b0);
            end
        end
        drive_idle(8);

        // Long reduction dropped by a flush and a multiply accepted on a flush edge
        drive_offer(1'b1, unit_simd, vredsum, sew_8, 5'd7, 1'b0);
        drive_offer(1'b0, unit_simd, vadd, sew_8, 5'd0, 1'b1);
        drive_offer(1'b1, unit_simd, vmul, sew_32, 5'd9, 1'b1);
        drive_idle(6);

        for (int n = 0; n < num_cycles; n++) begin
            drive_offer($urandom_range(3, 0) != 0,
                        ($urandom_range(9, 0) < 8) ? unit_simd : unit_t'($urandom_range(3, 0)),
                        instr_type_t'($urandom_range(17, 0)),
                        sew_t'($urandom_range(3, 0)),
                        rd_t'($urandom()),
                        $urandom_range(31, 0) == 0);
        end
        drive_idle(1);

        waited = 0;
        while (pending.size() != 0 && waited < drain_timeout) begin
            @(posedge clk_i);
            waited++;
        end
        if (pending.size() != 0) begin
            error_count++;
            $display("error: %0d writebacks still outstanding after %0d drain cycles",
                     pending.size(), drain_timeout);
        end
        drive_idle(idle_cycles);
        @(negedge clk_i);
        check_flag(stall_o, 1'b0, "stall_o after idle");

        asserts_failed = u_dut.u_asserts.assert_errors;
        $display("checks done: %0d mismatches, %0d other errors, %0d assertion failures",
                 mismatch_count, error_count, asserts_failed);
        if (mismatch_count == 0 && error_count == 0 && asserts_failed == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
